// File: Makefile
TOP = tb_wbuf

.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f -o V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log; then \
		echo "Simulation failed"; \
		exit 1; \
	fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/wbuf_cfg_regs.sv
`timescale 1ns/1ps

module wbuf_cfg_regs (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               cfg_we_i,
  input  logic [wbuf_pkg::CFG_ADDR_W-1:0]    cfg_addr_i,
  input  logic [wbuf_pkg::CFG_DATA_W-1:0]    cfg_wdata_i,
  output logic [wbuf_pkg::CFG_DATA_W-1:0]    cfg_rdata_o,
  output logic [wbuf_pkg::WIDTH_W-1:0]       width_o,
  output wbuf_pkg::cnt_t                     height_o,
  output logic [wbuf_pkg::ARRAY_H-1:0]       zero_set_o,
  output logic                               clear_o
);

  import wbuf_pkg::*;

  logic [WIDTH_W-1:0] width_q;
  cnt_t               height_q;
  logic [ARRAY_H-1:0] zero_set_q;
  logic               clear_q;
  logic [WIDTH_W-1:0] width_wr;
  cnt_t               height_wr;

  // Oversized values clamp to the physical array
  assign width_wr  = (cfg_wdata_i > CFG_DATA_W'(ROW_WORDS)) ? WIDTH_W'(ROW_WORDS)
                                                            : cfg_wdata_i[WIDTH_W-1:0];
  assign height_wr = (cfg_wdata_i > CFG_DATA_W'(ARRAY_H)) ? cnt_t'(ARRAY_H)
                                                          : cfg_wdata_i[CNT_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      width_q    <= WIDTH_W'(ROW_WORDS);
      height_q   <= cnt_t'(ARRAY_H);
      zero_set_q <= '0;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CFG_WIDTH:    width_q    <= width_wr;
        CFG_HEIGHT:   height_q   <= height_wr;
        CFG_ZERO_SET: zero_set_q <= cfg_wdata_i[ARRAY_H-1:0];
        default: ;
      endcase
    end
  end

  // Clear pulse is high for one cycle after the write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      clear_q <= 1'b0;
    end else begin
      clear_q <= cfg_we_i && (cfg_addr_i == CFG_CMD) && cfg_wdata_i[0];
    end
  end

  always_comb begin
    case (cfg_addr_i)
      CFG_WIDTH:    cfg_rdata_o = CFG_DATA_W'(width_q);
      CFG_HEIGHT:   cfg_rdata_o = CFG_DATA_W'(height_q);
      CFG_ZERO_SET: cfg_rdata_o = CFG_DATA_W'(zero_set_q);
      default:      cfg_rdata_o = '0;  // Command register is write only
    endcase
  end

  assign width_o    = width_q;
  assign height_o   = height_q;
  assign zero_set_o = zero_set_q;
  assign clear_o    = clear_q;

endmodule

// File: design/wbuf_loader.sv
`timescale 1ns/1ps

module wbuf_loader (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     row_valid_i,
  input  logic [wbuf_pkg::ROW_W-1:0]               row_data_i,
  input  logic [wbuf_pkg::WIDTH_W-1:0]             width_i,
  input  wbuf_pkg::cnt_t                           height_i,
  input  logic                                     clear_i,
  input  logic                                     pass_done_i,
  output logic                                     we_o,
  output wbuf_pkg::row_idx_t                       waddr_o,
  output wbuf_pkg::word_t [wbuf_pkg::ROW_WORDS-1:0] wdata_o,
  output logic                                     full_o,
  output logic                                     credit_o
);

  import wbuf_pkg::*;

  cnt_t rows_q;       // Rows loaded into the current tile
  logic full_q;
  cnt_t credits_q;    // Credits still owed to the sender
  cnt_t credit_add;
  logic row_in_range;

  assign row_in_range = (rows_q < height_i);

  // Words past the active width or rows past the active height load as zero
  for (genvar w = 0; w < ROW_WORDS; w++) begin : gen_pad
    assign wdata_o[w] = (row_in_range && (WIDTH_W'(w) < width_i)) ?
                        row_data_i[w*WORD_W +: WORD_W] : '0;
  end

  assign we_o    = row_valid_i;  // Sender holds a credit for every beat
  assign waddr_o = rows_q[ROW_IDX_W-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q <= '0;
      full_q <= 1'b0;
    end else if (clear_i || pass_done_i) begin
      rows_q <= '0;
      full_q <= 1'b0;
    end else if (row_valid_i) begin
      rows_q <= rows_q + cnt_t'(1);
      if (rows_q == cnt_t'(ARRAY_H - 1)) begin
        full_q <= 1'b1;
      end
    end
  end

  // A beat that lands with a clear is freed as well
  always_comb begin
    credit_add = '0;
    if (clear_i) begin
      credit_add = rows_q + cnt_t'(row_valid_i);
    end else if (pass_done_i) begin
      credit_add = cnt_t'(ARRAY_H);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= '0;
    end else begin
      credits_q <= credits_q + credit_add - cnt_t'(credit_o);
    end
  end

  assign credit_o = (credits_q != '0);  // One credit per cycle
  assign full_o   = full_q;

endmodule

// File: design/wbuf_pkg.sv
package wbuf_pkg;

  // Array geometry
  localparam int unsigned WORD_W    = 16;
  localparam int unsigned ARRAY_H   = 4;          // PE rows
  localparam int unsigned PIPE_REGS = 2;          // Pipeline registers per PE
  localparam int unsigned ELMS      = PIPE_REGS + 1;
  localparam int unsigned COLS      = 4;          // Column groups per row
  localparam int unsigned ROW_WORDS = ELMS * COLS;
  localparam int unsigned ROW_W     = ROW_WORDS * WORD_W;

  // Derived index widths
  localparam int unsigned ROW_IDX_W = $clog2(ARRAY_H);
  localparam int unsigned WIDX_W    = $clog2(ROW_WORDS);
  localparam int unsigned WIDTH_W   = WIDX_W + 1;  // Holds 0 to ROW_WORDS
  localparam int unsigned CNT_W     = $clog2(ARRAY_H + 1);
  localparam int unsigned ELM_W     = $clog2(ELMS);
  localparam int unsigned COL_W     = $clog2(COLS);

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [ROW_IDX_W-1:0] row_idx_t;
  typedef logic [WIDX_W-1:0]    word_idx_t;
  typedef logic [CNT_W-1:0]     cnt_t;

  // Configuration bus
  localparam int unsigned CFG_ADDR_W = 2;
  localparam int unsigned CFG_DATA_W = 32;

  localparam logic [CFG_ADDR_W-1:0] CFG_WIDTH    = 2'd0;
  localparam logic [CFG_ADDR_W-1:0] CFG_HEIGHT   = 2'd1;
  localparam logic [CFG_ADDR_W-1:0] CFG_ZERO_SET = 2'd2;
  localparam logic [CFG_ADDR_W-1:0] CFG_CMD      = 2'd3;  // Bit 0 issues a clear

endpackage

// File: design/wbuf_reader.sv
`timescale 1ns/1ps

module wbuf_reader (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    shift_i,
  input  logic                                    full_i,
  input  logic                                    clear_i,
  input  logic [wbuf_pkg::ARRAY_H-1:0]            zero_set_i,
  input  wbuf_pkg::word_t [wbuf_pkg::ARRAY_H-1:0] rdata_i,
  output logic                                    re_o,
  output wbuf_pkg::word_idx_t                     ridx_o,
  output logic                                    pass_done_o,
  output logic                                    w_valid_o,
  output wbuf_pkg::word_t [wbuf_pkg::ARRAY_H-1:0] w_o
);

  import wbuf_pkg::*;

  logic [ELM_W-1:0] el_q;
  logic [COL_W-1:0] col_q;
  logic             accept;
  logic             el_last;
  logic             col_last;
  logic             valid_q;

  assign accept   = shift_i && full_i;  // Shifts before the tile is full are dropped
  assign el_last  = (el_q == ELM_W'(ELMS - 1));
  assign col_last = (col_q == COL_W'(COLS - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (clear_i) begin
      el_q  <= '0;
      col_q <= '0;
    end else if (accept) begin
      el_q <= el_last ? '0 : el_q + ELM_W'(1);
      if (el_last) begin
        col_q <= col_last ? '0 : col_q + COL_W'(1);
      end
    end
  end

  // Element steps fastest within a column group
  assign ridx_o      = word_idx_t'(col_q) * word_idx_t'(ELMS) + word_idx_t'(el_q);
  assign re_o        = accept;
  assign pass_done_o = accept && el_last && col_last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  assign w_valid_o = valid_q;

  for (genvar h = 0; h < ARRAY_H; h++) begin : gen_mask
    assign w_o[h] = zero_set_i[h] ? '0 : rdata_i[h];
  end

endmodule

// File: design/wbuf_row_store.sv
`timescale 1ns/1ps

module wbuf_row_store (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  input  logic                                      we_i,
  input  wbuf_pkg::row_idx_t                        waddr_i,
  input  wbuf_pkg::word_t [wbuf_pkg::ROW_WORDS-1:0] wdata_i,
  input  logic                                      re_i,
  input  wbuf_pkg::word_idx_t                       ridx_i,
  output wbuf_pkg::word_t [wbuf_pkg::ARRAY_H-1:0]   rdata_o
);

  import wbuf_pkg::*;

  word_t [ARRAY_H-1:0][ROW_WORDS-1:0] mem_q;
  word_t [ARRAY_H-1:0]                rdata_q;
  logic  [ARRAY_H-1:0]                row_sel;

  // One-hot write decode
  always_comb begin
    row_sel = '0;
    if (we_i) begin
      row_sel[waddr_i] = 1'b1;
    end
  end

  for (genvar h = 0; h < ARRAY_H; h++) begin : gen_rows
    always_ff @(posedge clk_i) begin
      if (row_sel[h]) begin
        mem_q[h] <= wdata_i;
      end
    end

    // Every PE row reads the same word position
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rdata_q[h] <= '0;
      end else if (re_i) begin
        rdata_q[h] <= mem_q[h][ridx_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: design/wbuf_top.sv
`timescale 1ns/1ps

module wbuf_top (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  logic                                    cfg_we_i,
  input  logic [wbuf_pkg::CFG_ADDR_W-1:0]         cfg_addr_i,
  input  logic [wbuf_pkg::CFG_DATA_W-1:0]         cfg_wdata_i,
  output logic [wbuf_pkg::CFG_DATA_W-1:0]         cfg_rdata_o,
  input  logic                                    row_valid_i,
  input  logic [wbuf_pkg::ROW_W-1:0]              row_data_i,
  output logic                                    credit_o,
  input  logic                                    shift_i,
  output logic                                    ready_o,
  output logic                                    w_valid_o,
  output wbuf_pkg::word_t [wbuf_pkg::ARRAY_H-1:0] w_o
);

  import wbuf_pkg::*;

  logic [WIDTH_W-1:0]         width;
  cnt_t                       height;
  logic [ARRAY_H-1:0]         zero_set;
  logic                       clear;
  logic                       we;
  row_idx_t                   waddr;
  word_t [ROW_WORDS-1:0]      wdata;
  logic                       full;
  logic                       re;
  word_idx_t                  ridx;
  word_t [ARRAY_H-1:0]        rdata;
  logic                       pass_done;

  wbuf_cfg_regs i_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .width_o     ( width       ),
    .height_o    ( height      ),
    .zero_set_o  ( zero_set    ),
    .clear_o     ( clear       )
  );

  wbuf_loader i_loader (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .row_valid_i ( row_valid_i ),
    .row_data_i  ( row_data_i  ),
    .width_i     ( width       ),
    .height_i    ( height      ),
    .clear_i     ( clear       ),
    .pass_done_i ( pass_done   ),
    .we_o        ( we          ),
    .waddr_o     ( waddr       ),
    .wdata_o     ( wdata       ),
    .full_o      ( full        ),
    .credit_o    ( credit_o    )
  );

  wbuf_row_store i_row_store (
    .clk_i   ( clk_i  ),
    .rst_ni  ( rst_ni ),
    .we_i    ( we     ),
    .waddr_i ( waddr  ),
    .wdata_i ( wdata  ),
    .re_i    ( re     ),
    .ridx_i  ( ridx   ),
    .rdata_o ( rdata  )
  );

  wbuf_reader i_reader (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .shift_i     ( shift_i   ),
    .full_i      ( full      ),
    .clear_i     ( clear     ),
    .zero_set_i  ( zero_set  ),
    .rdata_i     ( rdata     ),
    .re_o        ( re        ),
    .ridx_o      ( ridx      ),
    .pass_done_o ( pass_done ),
    .w_valid_o   ( w_valid_o ),
    .w_o         ( w_o       )
  );

  assign ready_o = full;  // A full tile is ready to be shifted out

endmodule

// File: filelist.f
+incdir+sim
design/wbuf_pkg.sv
design/wbuf_cfg_regs.sv
design/wbuf_loader.sv
design/wbuf_row_store.sv
design/wbuf_reader.sv
design/wbuf_top.sv
sim/tb_wbuf.sv

// File: sim/tb_wbuf_ref.svh
`ifndef TB_WBUF_REF_SVH
`define TB_WBUF_REF_SVH

// Expected output word for PE row h at word index i
function automatic word_t expected_word(word_t raw, int h, int i, int width, int height,
                                        logic [ARRAY_H-1:0] mask);
  if (mask[h]) begin
    return '0;  // Masked PE row
  end
  if (h >= height || i >= width) begin
    return '0;  // Padding outside the active tile
  end
  return raw;
endfunction

// Rows handed back as credits
function automatic int credits_freed(bit is_clear, int rows_loaded);
  if (is_clear) begin
    return (rows_loaded > int'(ARRAY_H)) ? int'(ARRAY_H) : rows_loaded;
  end
  return int'(ARRAY_H);  // A finished pass frees the whole tile
endfunction

function automatic logic [CFG_DATA_W-1:0] reg_default(logic [CFG_ADDR_W-1:0] addr);
  case (addr)
    CFG_WIDTH:  return CFG_DATA_W'(ROW_WORDS);
    CFG_HEIGHT: return CFG_DATA_W'(ARRAY_H);
    default:    return '0;
  endcase
endfunction

// Read-back value after a write with oversized sizes clamped
function automatic logic [CFG_DATA_W-1:0] reg_after_write(logic [CFG_ADDR_W-1:0] addr,
                                                           logic [CFG_DATA_W-1:0] wdata);
  case (addr)
    CFG_WIDTH:    return (wdata > CFG_DATA_W'(ROW_WORDS)) ? CFG_DATA_W'(ROW_WORDS) : wdata;
    CFG_HEIGHT:   return (wdata > CFG_DATA_W'(ARRAY_H)) ? CFG_DATA_W'(ARRAY_H) : wdata;
    CFG_ZERO_SET: return CFG_DATA_W'(wdata[ARRAY_H-1:0]);
    default:      return '0;
  endcase
endfunction

`endif

// File: sim/tb_wbuf.sv
`timescale 1ns/1ps

module tb_wbuf;

  import wbuf_pkg::*;

  `include "tb_wbuf_ref.svh"

  // About 8 tile passes plus configuration and reset overhead
  localparam int TEST_CYCLES = 8 * (2 * int'(ARRAY_H) + int'(ROW_WORDS) + 8) + 60;
  localparam int WAIT_LIMIT  = 64;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    cfg_we_i;
  logic [CFG_ADDR_W-1:0]   cfg_addr_i;
  logic [CFG_DATA_W-1:0]   cfg_wdata_i;
  logic [CFG_DATA_W-1:0]   cfg_rdata_o;
  logic                    row_valid_i;
  logic [ROW_W-1:0]        row_data_i;
  logic                    credit_o;
  logic                    shift_i;
  logic                    ready_o;
  logic                    w_valid_o;
  word_t [ARRAY_H-1:0]     w_o;

  integer             seed;
  word_t              tile_q [ARRAY_H][ROW_WORDS];  // Raw rows as sent
  int                 exp_width;
  int                 exp_height;
  logic [ARRAY_H-1:0] exp_mask;
  int                 sent_rows;
  int                 pass_start;
  int                 mark;
  int                 credit_pulses = 0;
  int                 beat_total = 0;

  wbuf_top dut (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .cfg_we_i    ( cfg_we_i    ),
    .cfg_addr_i  ( cfg_addr_i  ),
    .cfg_wdata_i ( cfg_wdata_i ),
    .cfg_rdata_o ( cfg_rdata_o ),
    .row_valid_i ( row_valid_i ),
    .row_data_i  ( row_data_i  ),
    .credit_o    ( credit_o    ),
    .shift_i     ( shift_i     ),
    .ready_o     ( ready_o     ),
    .w_valid_o   ( w_valid_o   ),
    .w_o         ( w_o         )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t act, word_t exp);
    if (act !== exp) begin
      fail_run($sformatf("error: %s is 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic check_bit(string name, logic act, logic exp);
    if (act !== exp) begin
      fail_run($sformatf("error: %s is 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  task automatic check_reg(string name, logic [CFG_DATA_W-1:0] act,
                           logic [CFG_DATA_W-1:0] exp);
    if (act !== exp) begin
      fail_run($sformatf("error: %s is 0x%h, expected 0x%h", name, act, exp));
    end
  endtask

  function automatic int held_credits();
    return int'(ARRAY_H) + credit_pulses - sent_rows;
  endfunction

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic cfg_write(logic [CFG_ADDR_W-1:0] addr, logic [CFG_DATA_W-1:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    step();
    cfg_we_i    = 1'b0;
  endtask

  task automatic cfg_read(logic [CFG_ADDR_W-1:0] addr, logic [CFG_DATA_W-1:0] exp);
    cfg_addr_i = addr;
    step();  // Read data follows the address combinationally
    check_reg($sformatf("cfg_rdata_o at address %0d", addr), cfg_rdata_o, exp);
  endtask

  // Sender only drives a beat while it holds a credit
  task automatic send_row(int h);
    logic [ROW_W-1:0] row;
    word_t            word;
    int               cycles;
    cycles = 0;
    while (held_credits() == 0) begin
      step();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run("sender got no credit back from the buffer");
      end
    end
    for (int w = 0; w < int'(ROW_WORDS); w++) begin
      word = word_t'($random(seed));
      tile_q[h][w] = word;
      row[w*WORD_W +: WORD_W] = word;
    end
    row_valid_i = 1'b1;
    row_data_i  = row;
    sent_rows++;
    step();
    row_valid_i = 1'b0;
  endtask

  task automatic load_rows(int first, int last);
    for (int h = first; h <= last; h++) begin
      send_row(h);
    end
  endtask

  task automatic wait_ready();
    int cycles;
    cycles = 0;
    while (!ready_o) begin
      step();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run("ready_o did not rise after a full tile was sent");
      end
    end
  endtask

  task automatic shift_words(int n);
    shift_i = 1'b1;
    repeat (n) step();
    shift_i = 1'b0;
  endtask

  task automatic run_pass();
    pass_start = beat_total;
    shift_words(int'(ROW_WORDS));
    step();  // Last beat is compared in this cycle
    check_reg("beats in pass", beat_total - pass_start, ROW_WORDS);
    check_bit("ready_o", ready_o, 1'b0);
  endtask

  task automatic wait_credits(int from, int n);
    int cycles;
    cycles = 0;
    while (credit_pulses - from < n) begin
      step();
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        fail_run("credit return did not complete in time");
      end
    end
    repeat (3) step();
    check_reg("credit pulses", credit_pulses - from, n);
    check_bit("credit_o", credit_o, 1'b0);
  endtask

  // Sender credit tracking
  always @(negedge clk_i) begin
    if (rst_ni && credit_o) begin
      credit_pulses = credit_pulses + 1;
      if (held_credits() < 0 || held_credits() > int'(ARRAY_H)) begin
        fail_run("sender credit count left the range 0 to ARRAY_H");
      end
    end
  end

  // Compare every output beat with the reference
  always @(negedge clk_i) begin
    int idx;
    if (rst_ni && w_valid_o) begin
      idx = beat_total - pass_start;  // Words leave in ascending index order
      if (idx >= int'(ROW_WORDS)) begin
        fail_run("w_valid_o beat arrived past the last word of a pass");
      end else begin
        for (int h = 0; h < int'(ARRAY_H); h++) begin
          check_word($sformatf("w_o[%0d] at index %0d", h, idx), w_o[h],
                     expected_word(tile_q[h][idx], h, idx, exp_width, exp_height,
                                   exp_mask));
        end
        beat_total = beat_total + 1;
      end
    end
  end

  initial begin
    #(TEST_CYCLES * 20 + 500);
    fail_run("watchdog timeout, the tests did not finish");
  end

  initial begin
    seed        = 32'h52e9_f9bd;
    rst_ni      = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    row_valid_i = 1'b0;
    row_data_i  = '0;
    shift_i     = 1'b0;
    sent_rows   = 0;
    pass_start  = 0;
    mark        = 0;
    exp_width   = int'(ROW_WORDS);
    exp_height  = int'(ARRAY_H);
    exp_mask    = '0;
    repeat (10) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    step();

    // Reset state
    check_bit("ready_o", ready_o, 1'b0);
    check_bit("credit_o", credit_o, 1'b0);
    check_bit("w_valid_o", w_valid_o, 1'b0);
    for (int h = 0; h < int'(ARRAY_H); h++) begin
      check_word($sformatf("w_o[%0d]", h), w_o[h], '0);
    end
    for (int a = 0; a < 4; a++) begin
      cfg_read(CFG_ADDR_W'(a), reg_default(CFG_ADDR_W'(a)));
    end

    // Full tile
    load_rows(0, int'(ARRAY_H) - 1);
    wait_ready();
    mark = credit_pulses;
    run_pass();
    wait_credits(mark, credits_freed(1'b0, int'(ARRAY_H)));
    check_reg("sender credits", held_credits(), ARRAY_H);

    // Zero padding with an oversized width written first
    cfg_write(CFG_WIDTH, 32'd40);
    cfg_read(CFG_WIDTH, reg_after_write(CFG_WIDTH, 32'd40));
    cfg_write(CFG_WIDTH, 32'd7);
    cfg_write(CFG_HEIGHT, 32'd3);
    cfg_read(CFG_WIDTH, reg_after_write(CFG_WIDTH, 32'd7));
    cfg_read(CFG_HEIGHT, reg_after_write(CFG_HEIGHT, 32'd3));
    exp_width  = 7;
    exp_height = 3;
    load_rows(0, int'(ARRAY_H) - 1);
    wait_ready();
    mark = credit_pulses;
    run_pass();
    wait_credits(mark, credits_freed(1'b0, int'(ARRAY_H)));

    // Row masking on the full tile size
    cfg_write(CFG_WIDTH, CFG_DATA_W'(ROW_WORDS));
    cfg_write(CFG_HEIGHT, CFG_DATA_W'(ARRAY_H));
    cfg_write(CFG_ZERO_SET, 32'h5);
    cfg_read(CFG_ZERO_SET, reg_after_write(CFG_ZERO_SET, 32'h5));
    exp_width  = int'(ROW_WORDS);
    exp_height = int'(ARRAY_H);
    exp_mask   = ARRAY_H'(4'b0101);
    load_rows(0, int'(ARRAY_H) - 1);
    wait_ready();
    mark = credit_pulses;
    run_pass();
    wait_credits(mark, credits_freed(1'b0, int'(ARRAY_H)));
    cfg_write(CFG_ZERO_SET, 32'h0);
    exp_mask = '0;

    // Back-pressure with shifts on a partial tile
    load_rows(0, 1);
    check_bit("ready_o", ready_o, 1'b0);
    shift_i = 1'b1;
    for (int s = 0; s < 3; s++) begin
      step();
      check_bit("w_valid_o", w_valid_o, 1'b0);
    end
    shift_i = 1'b0;
    load_rows(2, int'(ARRAY_H) - 1);
    wait_ready();
    mark = credit_pulses;
    run_pass();
    load_rows(0, int'(ARRAY_H) - 1);  // Streams on credits as they return
    wait_ready();
    wait_credits(mark, credits_freed(1'b0, int'(ARRAY_H)));
    mark = credit_pulses;
    run_pass();
    wait_credits(mark, credits_freed(1'b0, int'(ARRAY_H)));

    // Clear in the middle of a pass and again after a partial load
    load_rows(0, int'(ARRAY_H) - 1);
    wait_ready();
    pass_start = beat_total;
    shift_words(5);
    step();
    mark = credit_pulses;
    cfg_write(CFG_CMD, 32'h1);
    wait_credits(mark, credits_freed(1'b1, int'(ARRAY_H)));
    check_bit("ready_o", ready_o, 1'b0);
    load_rows(0, 1);
    mark = credit_pulses;
    cfg_write(CFG_CMD, 32'h1);
    wait_credits(mark, credits_freed(1'b1, 2));
    load_rows(0, int'(ARRAY_H) - 1);
    wait_ready();
    mark = credit_pulses;
    run_pass();  // Restarts from index 0
    wait_credits(mark, credits_freed(1'b0, int'(ARRAY_H)));
    check_reg("sender credits", held_credits(), ARRAY_H);

    $display("Test OK");
    $finish;
  end

endmodule
